//--- lsu_subsys.f
+incdir+bench
verilog/lsu_pkg.sv
verilog/lsu_issue.sv
verilog/lsu_data_ram.sv
verilog/lsu_load_align.sv
verilog/lsu_subsys.sv
bench/tb_lsu_subsys.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the testbench with Verilator for an RV32 and an RV64 setup
cd "$(dirname "$0")" || exit 1
status=0
for cfg in "32 1" "64 0"; do
  set -- $cfg
  dir="obj_dir/x$1_w$2"
  log="sim_x$1_w$2.log"
  if ! verilator --binary --timing --top-module tb_lsu_subsys \
      -GXLEN=$1 -GMEM_WAIT=$2 --Mdir "$dir" -f lsu_subsys.f; then
    echo "build failed for XLEN=$1 MEM_WAIT=$2"
    exit 1
  fi
  "$dir/Vtb_lsu_subsys" > "$log" 2>&1
  run_status=$?
  cat "$log"
  if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status for XLEN=$1 MEM_WAIT=$2"
    status=1
  fi
  if grep -q "Simulation failed" "$log"; then
    status=1
  fi
done
exit $status

//--- bench/tb_lsu_tasks.svh
/* command driving and random numbers, included inside tb_lsu_subsys
   expects clk, cmd, cmd_vld, cmd_rdy, predict_rsp and abort_run in scope */
`ifndef TB_LSU_TASKS_SVH
`define TB_LSU_TASKS_SVH

logic [31:0] lfsr_q = 32'hc711_66fa;  // galois lfsr state

// n bits from the lfsr, one step per bit
function automatic logic [63:0] rand_bits(input int n);
  logic [63:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    v      = {v[62:0], lfsr_q[0]};
  end
  return v;
endfunction

function automatic lsu_pkg::lsu_cmd_t make_cmd(input logic we, input logic [2:0] f3,
                                               input int unsigned adr, input logic [63:0] wdt);
  lsu_pkg::lsu_cmd_t c;
  c.we  = we;
  c.f3  = lsu_pkg::lsu_f3_e'(f3);  // 3'b111 kept on purpose for illegal tests
  c.adr = 64'(adr);
  c.wdt = wdt;
  return c;
endfunction

// present one command, hold until the handshake edge, count stall cycles
task automatic send_cmd(input lsu_pkg::lsu_cmd_t c);
  int stall;
  stall   = 0;
  cmd     = c;
  cmd_vld = 1'b1;
  forever begin
    @(negedge clk);  // cmd_rdy settled mid cycle
    if (cmd_rdy) break;
    stall++;
  end
  predict_rsp(c);    // taken on the coming edge
  @(posedge clk);
  #1;
  cmd_vld = 1'b0;    // next send_cmd may raise it again right away
  assert (stall <= 1 + MEM_WAIT) else begin
    $display("command flow stalled for %0d cycles at %0t", stall, $time);
    abort_run();
  end
endtask

`endif

//--- bench/tb_lsu_subsys.sv
/* testbench of the load/store subsystem for one XLEN and MEM_WAIT per build
   random addresses stay inside the first REGION_WORDS words, written first */
`default_nettype none

module tb_lsu_subsys #(
  parameter int unsigned XLEN     = 32,
  parameter int unsigned MEM_WAIT = 1
);

localparam int unsigned MEM_WORDS    = 256;
localparam int unsigned BW           = XLEN/8;
localparam int unsigned REGION_WORDS = 16;                     // words under test
localparam int unsigned ADR_BITS     = $clog2(REGION_WORDS*BW);
localparam int unsigned N_RAND       = 400;
localparam int unsigned N_DIR        = 200;                    // upper bound on directed part
localparam int unsigned WD_LIMIT     = (N_DIR + N_RAND) * (4 + MEM_WAIT) * 10 + 2000;
localparam logic [2:0]  WORD_F3      = (XLEN == 64) ? 3'd3 : 3'd2;  // full bus word

logic              clk;
logic              rst;
lsu_pkg::lsu_cmd_t cmd;
logic              cmd_vld;
logic              cmd_rdy;
lsu_pkg::lsu_rsp_t rsp;
logic              rsp_vld;

logic [7:0]        ref_mem [int unsigned];  // byte model of the region
lsu_pkg::lsu_rsp_t exp_q [$];               // expected responses in command order

`include "tb_lsu_tasks.svh"

lsu_subsys #(
  .XLEN      (XLEN),
  .MEM_WORDS (MEM_WORDS),
  .MEM_WAIT  (MEM_WAIT)
) dut (
  .clk     (clk),
  .rst     (rst),
  .cmd     (cmd),
  .cmd_vld (cmd_vld),
  .cmd_rdy (cmd_rdy),
  .rsp     (rsp),
  .rsp_vld (rsp_vld)
);

always #5 clk = ~clk;

task automatic abort_run();
  $display("Simulation failed");
  $fatal(1, "run stopped");
endtask

//////////////////////////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////////////////////////

// expected response from the riscv load/store rules
// stores also update the byte model
task automatic predict_rsp(input lsu_pkg::lsu_cmd_t c);
  lsu_pkg::lsu_rsp_t r;
  logic [2:0]        f3;
  int unsigned       nb;   // access bytes
  int unsigned       a;
  logic [63:0]       v;
  logic              bad_cmd;
  f3      = c.f3;
  nb      = 1 << f3[1:0];
  a       = 32'(c.adr);
  bad_cmd = (f3 == 3'd7) || (c.we && f3[2]) || (nb > BW) || ((c.adr[2:0] % nb) != 0);
  r       = '0;
  v       = '0;
  if (bad_cmd) begin
    r.err = 1'b1;  // no bus access so we stays low
  end else if (c.we) begin
    r.we = 1'b1;
    for (int i = 0; i < nb; i++) ref_mem[a + i] = c.wdt[8*i +: 8];
  end else begin
    for (int i = 0; i < nb; i++) v[8*i +: 8] = ref_mem[a + i];  // little endian
    if (!f3[2]) begin
      for (int j = 8*nb; j < 64; j++) v[j] = v[8*nb-1];        // sign extend
    end
    r.rdt = v & (64'hffff_ffff_ffff_ffff >> (64 - XLEN));     // core width only
  end
  exp_q.push_back(r);
endtask

// response checks at mid cycle
always @(negedge clk) begin
  lsu_pkg::lsu_rsp_t exp_rsp;
  if (!rst && rsp_vld) begin
    assert (exp_q.size() != 0) else begin
      $display("response at %0t with no command outstanding", $time);
      abort_run();
    end
    exp_rsp = exp_q.pop_front();
    assert (rsp.err == exp_rsp.err) else begin
      $display("ERR %0t rsp.err got %b exp %b", $time, rsp.err, exp_rsp.err);
      abort_run();
    end
    assert (rsp.we == exp_rsp.we) else begin
      $display("ERR %0t rsp.we got %b exp %b", $time, rsp.we, exp_rsp.we);
      abort_run();
    end
    assert (rsp.rdt == exp_rsp.rdt) else begin
      $display("ERR %0t rsp.rdt got %h exp %h", $time, rsp.rdt, exp_rsp.rdt);
      abort_run();
    end
  end
end

initial begin
  #(WD_LIMIT);
  $display("timeout at %0t, responses or handshakes did not arrive", $time);
  abort_run();
end

//////////////////////////////////////////////////////////////////////
// test sequence
//////////////////////////////////////////////////////////////////////

initial begin
  clk     = 1'b0;
  rst     = 1'b1;
  cmd     = '0;
  cmd_vld = 1'b0;
  repeat (10) @(posedge clk);
  #1;
  rst = 1'b0;
  @(negedge clk);
  // idle state before the first command
  assert (!rsp_vld) else begin
    $display("ERR %0t rsp_vld got %b exp 0", $time, rsp_vld);
    abort_run();
  end
  assert (cmd_rdy) else begin
    $display("ERR %0t cmd_rdy got %b exp 1", $time, cmd_rdy);
    abort_run();
  end
  @(posedge clk);
  #1;

  // word round trip that also fills the region
  for (int w = 0; w < REGION_WORDS; w++) begin
    send_cmd(make_cmd(1'b1, WORD_F3, w*BW, rand_bits(XLEN)));
  end
  for (int w = 0; w < REGION_WORDS; w++) begin
    send_cmd(make_cmd(1'b0, lsu_pkg::LW, w*BW, '0));
    if (XLEN == 64) begin
      send_cmd(make_cmd(1'b0, lsu_pkg::LW, w*BW + 4, '0));  // upper half
      send_cmd(make_cmd(1'b0, lsu_pkg::LD, w*BW, '0));
    end
  end

  // partial stores to word 2 by bytes and word 3 by halves
  for (int b = 0; b < BW; b++) begin
    send_cmd(make_cmd(1'b1, lsu_pkg::SB, 2*BW + b, rand_bits(8)));
  end
  for (int b = 0; b < BW; b += 2) begin
    send_cmd(make_cmd(1'b1, lsu_pkg::SH, 3*BW + b, rand_bits(16)));
  end
  for (int w = 2; w < 4; w++) begin
    for (int b = 0; b < BW; b++) begin
      send_cmd(make_cmd(1'b0, lsu_pkg::LB, w*BW + b, '0));
      send_cmd(make_cmd(1'b0, lsu_pkg::LBU, w*BW + b, '0));
      if (b % 2 == 0) begin
        send_cmd(make_cmd(1'b0, lsu_pkg::LH, w*BW + b, '0));
        send_cmd(make_cmd(1'b0, lsu_pkg::LHU, w*BW + b, '0));
      end
      if (b % 4 == 0) send_cmd(make_cmd(1'b0, lsu_pkg::LWU, w*BW + b, '0));
    end
  end

  // rejected commands then proof that memory is unchanged
  send_cmd(make_cmd(1'b1, lsu_pkg::SH, 4*BW + 1, rand_bits(16)));
  send_cmd(make_cmd(1'b0, lsu_pkg::LW, 4*BW + 2, '0));
  send_cmd(make_cmd(1'b1, lsu_pkg::SW, 4*BW + 1, rand_bits(32)));
  send_cmd(make_cmd(1'b0, lsu_pkg::LH, 4*BW + 3, '0));
  send_cmd(make_cmd(1'b0, lsu_pkg::LW, 4*BW, '0));
  send_cmd(make_cmd(1'b1, lsu_pkg::SD, 5*BW, rand_bits(64)));  // error on rv32
  send_cmd(make_cmd(1'b0, lsu_pkg::LD, 5*BW, '0));
  send_cmd(make_cmd(1'b0, 3'd7, 5*BW, '0));                     // unused code
  send_cmd(make_cmd(1'b1, lsu_pkg::LBU, 5*BW, rand_bits(8)));   // no unsigned store
  send_cmd(make_cmd(1'b0, lsu_pkg::LD, 4*BW + 4, '0));
  send_cmd(make_cmd(1'b0, lsu_pkg::LW, 5*BW, '0));

  // random back-to-back stream
  for (int n = 0; n < N_RAND; n++) begin
    send_cmd(make_cmd(1'(rand_bits(1)), 3'(rand_bits(3)), 32'(rand_bits(ADR_BITS)),
                      rand_bits(XLEN)));
  end

  while (exp_q.size() != 0) @(negedge clk);
  repeat (4) @(negedge clk);  // catch stray responses
  $display("Simulation completed successfully");
  $finish;
end

endmodule

`default_nettype wire

//--- verilog/lsu_subsys.sv
/* load/store subsystem top, issue stage, data memory and load align in a row
   XLEN is 32 or 64 and MEM_WAIT 0 to 3 */
`default_nettype none

module lsu_subsys #(
  parameter  int unsigned XLEN      = 32,
  parameter  int unsigned MEM_WORDS = 256,
  parameter  int unsigned MEM_WAIT  = 0,
  localparam int unsigned BW        = XLEN/8,
  localparam int unsigned WW        = $clog2(BW)
) (
  input  logic              clk,
  input  logic              rst,
  input  lsu_pkg::lsu_cmd_t cmd,
  input  logic              cmd_vld,
  output logic              cmd_rdy,
  output lsu_pkg::lsu_rsp_t rsp,
  output logic              rsp_vld
);

//////////////////////////////////////////////////////////////////////
// internal buses
//////////////////////////////////////////////////////////////////////

// data bus
logic             ls_vld;
logic             ls_wen;
logic [XLEN-1:0]  ls_adr;
logic [BW-1:0]    ls_ben;
logic [XLEN-1:0]  ls_wdt;
logic             ls_rdy;
logic [XLEN-1:0]  ls_rdt;

// issue to align
logic             rd_xfer;
logic [WW-1:0]    rd_ofs;
lsu_pkg::lsu_f3_e rd_f3;
logic             wr_xfer;
logic             bad;      // error strobe

//////////////////////////////////////////////////////////////////////
// stages
//////////////////////////////////////////////////////////////////////

lsu_issue #(
  .XLEN (XLEN)
) u_issue (
  .clk     (clk),
  .rst     (rst),
  .cmd     (cmd),
  .cmd_vld (cmd_vld),
  .cmd_rdy (cmd_rdy),
  .ls_vld  (ls_vld),
  .ls_wen  (ls_wen),
  .ls_adr  (ls_adr),
  .ls_ben  (ls_ben),
  .ls_wdt  (ls_wdt),
  .ls_rdy  (ls_rdy),
  .rd_xfer (rd_xfer),
  .rd_ofs  (rd_ofs),
  .rd_f3   (rd_f3),
  .wr_xfer (wr_xfer),
  .bad     (bad)
);

lsu_data_ram #(
  .XLEN      (XLEN),
  .MEM_WORDS (MEM_WORDS),
  .MEM_WAIT  (MEM_WAIT)
) u_ram (
  .clk    (clk),
  .rst    (rst),
  .ls_vld (ls_vld),
  .ls_wen (ls_wen),
  .ls_adr (ls_adr),
  .ls_ben (ls_ben),
  .ls_wdt (ls_wdt),
  .ls_rdy (ls_rdy),
  .ls_rdt (ls_rdt)
);

lsu_load_align #(
  .XLEN (XLEN)
) u_align (
  .clk     (clk),
  .rst     (rst),
  .rd_xfer (rd_xfer),
  .rd_ofs  (rd_ofs),
  .rd_f3   (rd_f3),
  .wr_xfer (wr_xfer),
  .bad     (bad),
  .ls_rdt  (ls_rdt),
  .rsp     (rsp),
  .rsp_vld (rsp_vld)
);

endmodule

`default_nettype wire

//--- verilog/lsu_load_align.sv
/* load alignment and response register
   expects at most one of rd_xfer, wr_xfer and bad per cycle
   rsp fields are meaningful only while rsp_vld is high */
`default_nettype none

module lsu_load_align #(
  parameter  int unsigned XLEN = 32,
  localparam int unsigned BW   = XLEN/8,
  localparam int unsigned WW   = $clog2(BW)
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              rd_xfer,
  input  logic [WW-1:0]     rd_ofs,
  input  lsu_pkg::lsu_f3_e  rd_f3,
  input  logic              wr_xfer,
  input  logic              bad,
  input  logic [XLEN-1:0]   ls_rdt,
  output lsu_pkg::lsu_rsp_t rsp,
  output logic              rsp_vld
);

// response owed next cycle
typedef enum logic [1:0] {
  PND_NONE,
  PND_LOAD,
  PND_STORE,
  PND_ERR
} pnd_e;

pnd_e               pnd_q;
logic [WW-1:0]      ofs_q;  // lane of the read in flight
lsu_pkg::lsu_f3_e   f3_q;
lsu_pkg::lsu_word_t sht;    // word moved down to lane 0
lsu_pkg::lsu_word_t ext;    // extended result

always_ff @(posedge clk, posedge rst) begin
  if (rst) begin
    pnd_q <= PND_NONE;
  end else if (rd_xfer) begin
    pnd_q <= PND_LOAD;
  end else if (wr_xfer) begin
    pnd_q <= PND_STORE;
  end else if (bad) begin
    pnd_q <= PND_ERR;
  end else begin
    pnd_q <= PND_NONE;
  end
end

// read side info latched at the bus transfer
always_ff @(posedge clk) begin
  if (rd_xfer) begin
    ofs_q <= rd_ofs;
    f3_q  <= rd_f3;
  end
end

//////////////////////////////////////////////////////////////////////
// shift and extend
//////////////////////////////////////////////////////////////////////

always_comb begin
  sht = lsu_pkg::lsu_word_t'(ls_rdt) >> (8 * ofs_q);
  case (f3_q)
    lsu_pkg::LB:  ext = lsu_pkg::lsu_word_t'($signed(sht[7:0]));
    lsu_pkg::LH:  ext = lsu_pkg::lsu_word_t'($signed(sht[15:0]));
    lsu_pkg::LW:  ext = lsu_pkg::lsu_word_t'($signed(sht[31:0]));
    lsu_pkg::LD:  ext = sht;
    lsu_pkg::LBU: ext = lsu_pkg::lsu_word_t'(sht[7:0]);
    lsu_pkg::LHU: ext = lsu_pkg::lsu_word_t'(sht[15:0]);
    lsu_pkg::LWU: ext = lsu_pkg::lsu_word_t'(sht[31:0]);
    default:      ext = '0;
  endcase
end

//////////////////////////////////////////////////////////////////////
// response register
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk, posedge rst) begin
  if (rst) rsp_vld <= 1'b0;
  else     rsp_vld <= (pnd_q != PND_NONE);
end

always_ff @(posedge clk) begin
  rsp.we  <= (pnd_q == PND_STORE);
  rsp.err <= (pnd_q == PND_ERR);
  // only low XLEN bits carry data
  rsp.rdt <= (pnd_q == PND_LOAD) ? lsu_pkg::lsu_word_t'(ext[XLEN-1:0]) : '0;
end

endmodule

`default_nettype wire

//--- verilog/lsu_data_ram.sv
/* byte-enabled data memory behind the load/store bus
   index wraps modulo MEM_WORDS and the array content is undefined after reset
   ls_rdy follows ls_vld after MEM_WAIT cycles (0 to 3) */
`default_nettype none

module lsu_data_ram #(
  parameter  int unsigned XLEN      = 32,
  parameter  int unsigned MEM_WORDS = 256,
  parameter  int unsigned MEM_WAIT  = 0,
  localparam int unsigned BW        = XLEN/8,
  localparam int unsigned WW        = $clog2(BW),
  localparam int unsigned IW        = $clog2(MEM_WORDS),
  localparam int unsigned CW        = $clog2(MEM_WAIT+2)
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            ls_vld,
  input  logic            ls_wen,
  input  logic [XLEN-1:0] ls_adr,
  input  logic [BW-1:0]   ls_ben,
  input  logic [XLEN-1:0] ls_wdt,
  output logic            ls_rdy,
  output logic [XLEN-1:0] ls_rdt
);

logic [CW-1:0]      wait_cnt;  // cycles spent waiting on this request
logic [IW-1:0]      idx;       // word index
logic               xfer;
logic [BW-1:0][7:0] wdt_b;     // write data by byte

// word array
logic [BW-1:0][7:0] mem [MEM_WORDS];

//////////////////////////////////////////////////////////////////////
// wait states
//////////////////////////////////////////////////////////////////////

assign ls_rdy = ls_vld & (wait_cnt == CW'(MEM_WAIT));
assign xfer   = ls_vld & ls_rdy;

always_ff @(posedge clk, posedge rst) begin
  if (rst) begin
    wait_cnt <= '0;
  end else if (xfer) begin
    wait_cnt <= '0;  // next request starts over
  end else if (ls_vld) begin
    wait_cnt <= wait_cnt + 1'b1;
  end
end

//////////////////////////////////////////////////////////////////////
// array access
//////////////////////////////////////////////////////////////////////

// lane bits dropped, then wrap
assign idx   = IW'((ls_adr >> WW) % MEM_WORDS);
assign wdt_b = ls_wdt;

// store only enabled bytes
always_ff @(posedge clk) begin
  if (xfer && ls_wen) begin
    for (int b = 0; b < BW; b++) begin
      if (ls_ben[b]) mem[idx][b] <= wdt_b[b];
    end
  end
end

// full word read, valid the cycle after the transfer
always_ff @(posedge clk) begin
  if (xfer && !ls_wen) ls_rdt <= mem[idx];
end

endmodule

`default_nettype wire

//--- verilog/lsu_issue.sv
/* command register and bus request of the load/store path
   misaligned and illegal commands never reach the bus
   an error command is only taken while the request register is empty */
`default_nettype none

module lsu_issue #(
  parameter  int unsigned XLEN = 32,
  localparam int unsigned BW   = XLEN/8,
  localparam int unsigned WW   = $clog2(BW)
) (
  input  logic              clk,
  input  logic              rst,
  // command in
  input  lsu_pkg::lsu_cmd_t cmd,
  input  logic              cmd_vld,
  output logic              cmd_rdy,
  // data bus
  output logic              ls_vld,
  output logic              ls_wen,
  output logic [XLEN-1:0]   ls_adr,
  output logic [BW-1:0]     ls_ben,
  output logic [XLEN-1:0]   ls_wdt,
  input  logic              ls_rdy,
  // to load align stage
  output logic              rd_xfer,
  output logic [WW-1:0]     rd_ofs,
  output lsu_pkg::lsu_f3_e  rd_f3,
  output logic              wr_xfer,
  output logic              bad
);

logic [1:0]         sz;     // log2 of access bytes
logic               ill;    // unused code or too wide
logic               mal;    // misaligned
logic               err;
logic [2:0]         amsk;   // address bits that must be zero
logic [7:0]         bmsk;   // byte mask at lane 0
lsu_pkg::lsu_word_t dmsk;   // data mask at lane 0
logic [WW-1:0]      lane;
logic               acc;    // command handshake
logic               xfer;   // bus handshake
logic               vld_q;
lsu_pkg::lsu_req_t  req_d;
lsu_pkg::lsu_req_t  req_q;

//////////////////////////////////////////////////////////////////////
// decode
//////////////////////////////////////////////////////////////////////

// same size rule for loads and stores
always_comb begin
  sz  = 2'd0;
  ill = 1'b0;
  if (cmd.we) begin
    case (cmd.f3)
      lsu_pkg::SB: sz = 2'd0;
      lsu_pkg::SH: sz = 2'd1;
      lsu_pkg::SW: sz = 2'd2;
      lsu_pkg::SD: sz = 2'd3;
      default:     ill = 1'b1;  // no unsigned stores
    endcase
  end else begin
    case (cmd.f3)
      lsu_pkg::LB, lsu_pkg::LBU: sz = 2'd0;
      lsu_pkg::LH, lsu_pkg::LHU: sz = 2'd1;
      lsu_pkg::LW, lsu_pkg::LWU: sz = 2'd2;
      lsu_pkg::LD:               sz = 2'd3;
      default:                   ill = 1'b1;
    endcase
  end
  if (sz == 2'd3 && XLEN < 64) ill = 1'b1;  // doubleword needs RV64
end

always_comb begin
  case (sz)
    2'd0: begin
      amsk = 3'b000;
      bmsk = 8'h01;
      dmsk = 64'h00000000_000000ff;
    end
    2'd1: begin
      amsk = 3'b001;
      bmsk = 8'h03;
      dmsk = 64'h00000000_0000ffff;
    end
    2'd2: begin
      amsk = 3'b011;
      bmsk = 8'h0f;
      dmsk = 64'h00000000_ffffffff;
    end
    default: begin
      amsk = 3'b111;
      bmsk = 8'hff;
      dmsk = 64'hffffffff_ffffffff;
    end
  endcase
end

assign mal  = |(cmd.adr[2:0] & amsk);
assign err  = mal | ill;
assign lane = cmd.adr[WW-1:0];

//////////////////////////////////////////////////////////////////////
// handshakes and request register
//////////////////////////////////////////////////////////////////////

assign xfer    = vld_q & ls_rdy;
// errors wait for an empty register so their response never meets a transfer
assign cmd_rdy = ~vld_q | (xfer & ~err);
assign acc     = cmd_vld & cmd_rdy;
assign bad     = acc & err;

always_comb begin
  req_d.wen = cmd.we;
  req_d.f3  = cmd.f3;
  req_d.ofs = 3'(lane);
  req_d.adr = cmd.adr & ~lsu_pkg::lsu_word_t'(BW-1);  // drop lane bits
  req_d.ben = bmsk << lane;
  req_d.wdt = (cmd.wdt & dmsk) << (8 * lane);       // mask then move to lane
end

always_ff @(posedge clk, posedge rst) begin
  if (rst) begin
    vld_q <= 1'b0;
  end else if (acc && !err) begin
    vld_q <= 1'b1;  // refill, also on the transfer edge
  end else if (xfer) begin
    vld_q <= 1'b0;
  end
end

always_ff @(posedge clk) begin
  if (acc && !err) req_q <= req_d;  // held until ls_rdy
end

assign ls_vld  = vld_q;
assign ls_wen  = req_q.wen;
assign ls_adr  = req_q.adr[XLEN-1:0];
assign ls_ben  = req_q.ben[BW-1:0];
assign ls_wdt  = req_q.wdt[XLEN-1:0];

assign rd_xfer = xfer & ~req_q.wen;
assign wr_xfer = xfer &  req_q.wen;
assign rd_ofs  = req_q.ofs[WW-1:0];
assign rd_f3   = req_q.f3;

endmodule

`default_nettype wire

//--- verilog/lsu_pkg.sv
/* shared types of the load/store path
   structs are sized for XLEN_MAX and narrower cores use the low XLEN bits */
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN_MAX = 64;  // widest supported core

  typedef logic [XLEN_MAX-1:0] lsu_word_t;  // one full-width data/address word

  ////////////////////////////////////////////////////////////////////
  // funct3 codes
  ////////////////////////////////////////////////////////////////////

  // RV load funct3, code 3'b111 unused
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LD  = 3'b011,
    LBU = 3'b100,
    LHU = 3'b101,
    LWU = 3'b110
  } lsu_f3_e;

  // stores reuse the signed load codes, told apart by we
  localparam lsu_f3_e SB = LB;
  localparam lsu_f3_e SH = LH;
  localparam lsu_f3_e SW = LW;
  localparam lsu_f3_e SD = LD;

  ////////////////////////////////////////////////////////////////////
  // command, bus request, response
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic      we;   // store when set
    lsu_f3_e   f3;   // size and sign
    lsu_word_t adr;  // byte address
    lsu_word_t wdt;  // store data, right aligned
  } lsu_cmd_t;

  typedef struct packed {
    logic                  wen;  // bus write
    lsu_f3_e               f3;   // kept for the read path
    logic [2:0]            ofs;  // byte lane of the access
    lsu_word_t             adr;  // word aligned
    logic [XLEN_MAX/8-1:0] ben;  // byte enables
    lsu_word_t             wdt;  // lane shifted store data
  } lsu_req_t;

  typedef struct packed {
    logic      we;   // echo of command type
    logic      err;  // misaligned or illegal
    lsu_word_t rdt;  // load result, zero otherwise
  } lsu_rsp_t;

endpackage

`default_nettype wire
